/* common/xbar_defines.svh */
// Crossbar configuration
// Port counts, bus widths and the outstanding-transaction depth
// shared by the package, the RTL and the testbench

`ifndef XBAR_DEFINES_SVH
`define XBAR_DEFINES_SVH

// Number of initiator ports
`define XBAR_N_INIT 2

// Number of target ports, one address rule each
`define XBAR_N_TGT 2

`define XBAR_ADDR_W 16  // Request address width
`define XBAR_DATA_W 32  // Read and write data width

// Outstanding transactions per demux and per mux
`define XBAR_MAX_TRANS 4

`endif

/* common/xbar_pkg.sv */
// Crossbar types
// Address, data, port index, response code and address rule types
// used by the decoder, demux, mux and top level

`include "xbar_defines.svh"

package xbar_pkg;

  typedef logic [`XBAR_ADDR_W-1:0] addr_t;
  typedef logic [`XBAR_DATA_W-1:0] data_t;

  // One extra code point names the decode-error responder
  typedef logic [$clog2(`XBAR_N_TGT + 1)-1:0] tgt_idx_t;

  typedef logic [((`XBAR_N_INIT > 1) ? $clog2(`XBAR_N_INIT) : 1)-1:0] init_idx_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_DECERR = 2'b11
  } resp_e;

  // Address window [start_addr, end_addr) mapped to one target
  typedef struct packed {
    tgt_idx_t idx;
    addr_t    start_addr;
    addr_t    end_addr;    // Exclusive
  } addr_rule_t;

endpackage

/* rtl/xbar_fifo.sv */
// In-order FIFO for routing indices
// Register array with read and write pointers and an occupancy counter

`timescale 1ns/1ps

module xbar_fifo #(
  parameter int unsigned DEPTH     = 4,
  parameter type         payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;

  assign data_o  = mem_q[rd_ptr_q];  // Head is visible without a pop
  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == CNT_W'(DEPTH));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_i && !pop_i) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!push_i && pop_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Callers gate their handshakes with full_o and empty_o
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full_o);
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> !empty_o);

endmodule

/* rtl/xbar_addr_decode.sv */
// Address decoder
// Matches an address against the rule table, last matching rule wins.
// Unmatched addresses go to the default target when enabled,
// otherwise they are flagged and steered to the error index

`timescale 1ns/1ps
`include "xbar_defines.svh"

module xbar_addr_decode
  import xbar_pkg::*;
(
  input  addr_t                          addr_i,
  input  addr_rule_t [`XBAR_N_TGT-1:0]   addr_map_i,
  input  logic                           en_default_i,
  input  tgt_idx_t                       default_tgt_i,
  output tgt_idx_t                       idx_o,
  output logic                           dec_error_o
);

  logic matched;

  always_comb begin
    matched     = 1'b0;
    idx_o       = tgt_idx_t'(`XBAR_N_TGT);
    dec_error_o = 1'b0;

    for (int r = 0; r < `XBAR_N_TGT; r++) begin
      if (addr_i >= addr_map_i[r].start_addr && addr_i < addr_map_i[r].end_addr) begin
        matched = 1'b1;
        idx_o   = addr_map_i[r].idx;  // Later rules override earlier ones
      end
    end

    if (!matched) begin
      if (en_default_i) begin
        idx_o = default_tgt_i;
      end else begin
        dec_error_o = 1'b1;
      end
    end
  end

endmodule

/* demux/xbar_demux.sv */
// Initiator-side demux
// Steers each request to its decoded target and records the target
// index in a tracker FIFO so that responses return in issue order.
// Requests to the error index are answered locally with DECERR

`timescale 1ns/1ps
`include "xbar_defines.svh"

module xbar_demux
  import xbar_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  tgt_idx_t                     sel_i,
  input  logic                         init_req_valid_i,
  output logic                         init_req_ready_o,
  input  addr_t                        init_req_addr_i,
  input  logic                         init_req_write_i,
  input  data_t                        init_req_wdata_i,
  output logic                         init_rsp_valid_o,
  input  logic                         init_rsp_ready_i,
  output data_t                        init_rsp_rdata_o,
  output resp_e                        init_rsp_code_o,
  output logic  [`XBAR_N_TGT-1:0]      tgt_req_valid_o,
  input  logic  [`XBAR_N_TGT-1:0]      tgt_req_ready_i,
  output addr_t [`XBAR_N_TGT-1:0]      tgt_req_addr_o,
  output logic  [`XBAR_N_TGT-1:0]      tgt_req_write_o,
  output data_t [`XBAR_N_TGT-1:0]      tgt_req_wdata_o,
  input  logic  [`XBAR_N_TGT-1:0]      tgt_rsp_valid_i,
  output logic  [`XBAR_N_TGT-1:0]      tgt_rsp_ready_o,
  input  data_t [`XBAR_N_TGT-1:0]      tgt_rsp_rdata_i,
  input  resp_e [`XBAR_N_TGT-1:0]      tgt_rsp_code_i
);

  localparam tgt_idx_t ERR_IDX = tgt_idx_t'(`XBAR_N_TGT);

  logic     fifo_full;
  logic     fifo_empty;
  tgt_idx_t head_idx;
  logic     sel_err;
  logic     sel_ready;
  logic     req_hs;
  logic     rsp_hs;
  logic     err_pend_q;  // DECERR response waiting to be returned

  assign sel_err = (sel_i == ERR_IDX);

  always_comb begin
    sel_ready = sel_err && !err_pend_q;  // Error responder holds one response
    for (int j = 0; j < `XBAR_N_TGT; j++) begin
      tgt_req_valid_o[j] = init_req_valid_i && !fifo_full && (sel_i == tgt_idx_t'(j));
      tgt_req_addr_o[j]  = init_req_addr_i;
      tgt_req_write_o[j] = init_req_write_i;
      tgt_req_wdata_o[j] = init_req_wdata_i;
      if (sel_i == tgt_idx_t'(j)) begin
        sel_ready = tgt_req_ready_i[j];
      end
    end
  end

  assign init_req_ready_o = !fifo_full && sel_ready;
  assign req_hs           = init_req_valid_i && init_req_ready_o;

  // Only the target at the FIFO head may answer
  always_comb begin
    init_rsp_valid_o = 1'b0;
    init_rsp_rdata_o = '0;
    init_rsp_code_o  = RESP_OKAY;
    tgt_rsp_ready_o  = '0;
    if (!fifo_empty && head_idx == ERR_IDX) begin
      init_rsp_valid_o = err_pend_q;
      init_rsp_code_o  = RESP_DECERR;
    end
    for (int j = 0; j < `XBAR_N_TGT; j++) begin
      if (!fifo_empty && head_idx == tgt_idx_t'(j)) begin
        init_rsp_valid_o   = tgt_rsp_valid_i[j];
        init_rsp_rdata_o   = tgt_rsp_rdata_i[j];
        init_rsp_code_o    = tgt_rsp_code_i[j];
        tgt_rsp_ready_o[j] = init_rsp_ready_i;
      end
    end
  end

  assign rsp_hs = init_rsp_valid_o && init_rsp_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_pend_q <= 1'b0;
    end else if (req_hs && sel_err) begin
      err_pend_q <= 1'b1;
    end else if (rsp_hs && head_idx == ERR_IDX) begin
      err_pend_q <= 1'b0;
    end
  end

  xbar_fifo #(
    .DEPTH     ( `XBAR_MAX_TRANS ),
    .payload_t ( tgt_idx_t       )
  ) i_track_fifo (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .push_i  ( req_hs     ),
    .data_i  ( sel_i      ),
    .pop_i   ( rsp_hs     ),
    .data_o  ( head_idx   ),
    .empty_o ( fifo_empty ),
    .full_o  ( fifo_full  )
  );

  // Decoder output and default target must not move under a waiting request
  a_sel_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    init_req_valid_i && !init_req_ready_o |=> $stable(sel_i));

endmodule

/* mux/xbar_mux.sv */
// Target-side mux
// Round-robin arbitration among initiators with the grant locked
// until the target accepts. Granted initiator indices are queued
// so that each response goes back to the initiator that issued it

`timescale 1ns/1ps
`include "xbar_defines.svh"

module xbar_mux
  import xbar_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic  [`XBAR_N_INIT-1:0]      init_req_valid_i,
  output logic  [`XBAR_N_INIT-1:0]      init_req_ready_o,
  input  addr_t [`XBAR_N_INIT-1:0]      init_req_addr_i,
  input  logic  [`XBAR_N_INIT-1:0]      init_req_write_i,
  input  data_t [`XBAR_N_INIT-1:0]      init_req_wdata_i,
  output logic  [`XBAR_N_INIT-1:0]      init_rsp_valid_o,
  input  logic  [`XBAR_N_INIT-1:0]      init_rsp_ready_i,
  output data_t [`XBAR_N_INIT-1:0]      init_rsp_rdata_o,
  output resp_e [`XBAR_N_INIT-1:0]      init_rsp_code_o,
  output logic                          tgt_req_valid_o,
  input  logic                          tgt_req_ready_i,
  output addr_t                         tgt_req_addr_o,
  output logic                          tgt_req_write_o,
  output data_t                         tgt_req_wdata_o,
  input  logic                          tgt_rsp_valid_i,
  output logic                          tgt_rsp_ready_o,
  input  data_t                         tgt_rsp_rdata_i,
  input  resp_e                         tgt_rsp_code_i
);

  init_idx_t prio_q;      // Highest-priority initiator this cycle
  init_idx_t lock_idx_q;
  logic      lock_q;
  init_idx_t gnt_idx;
  logic      gnt_valid;
  init_idx_t head_idx;
  logic      fifo_full;
  logic      fifo_empty;
  logic      req_hs;
  logic      rsp_hs;

  always_comb begin
    int unsigned cand;
    gnt_valid = 1'b0;
    gnt_idx   = prio_q;
    for (int unsigned k = 0; k < `XBAR_N_INIT; k++) begin
      cand = (32'(prio_q) + k) % `XBAR_N_INIT;
      if (!gnt_valid && init_req_valid_i[cand]) begin
        gnt_valid = 1'b1;
        gnt_idx   = init_idx_t'(cand);
      end
    end
    if (lock_q) begin  // Offered request keeps the grant
      gnt_valid = init_req_valid_i[lock_idx_q];
      gnt_idx   = lock_idx_q;
    end
  end

  assign tgt_req_valid_o = gnt_valid && !fifo_full;
  assign tgt_req_addr_o  = init_req_addr_i[gnt_idx];
  assign tgt_req_write_o = init_req_write_i[gnt_idx];
  assign tgt_req_wdata_o = init_req_wdata_i[gnt_idx];
  assign req_hs          = tgt_req_valid_o && tgt_req_ready_i;

  always_comb begin
    for (int i = 0; i < `XBAR_N_INIT; i++) begin
      init_req_ready_o[i] = req_hs && (gnt_idx == init_idx_t'(i));
      init_rsp_valid_o[i] = tgt_rsp_valid_i && !fifo_empty && (head_idx == init_idx_t'(i));
      init_rsp_rdata_o[i] = tgt_rsp_rdata_i;
      init_rsp_code_o[i]  = tgt_rsp_code_i;
    end
  end

  assign tgt_rsp_ready_o = !fifo_empty && init_rsp_ready_i[head_idx];
  assign rsp_hs          = tgt_rsp_valid_i && tgt_rsp_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prio_q     <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (req_hs) begin
      lock_q <= 1'b0;
      prio_q <= (gnt_idx == init_idx_t'(`XBAR_N_INIT - 1)) ? '0 : gnt_idx + 1'b1;
    end else if (tgt_req_valid_o) begin
      lock_q     <= 1'b1;  // Target stalled
      lock_idx_q <= gnt_idx;
    end
  end

  xbar_fifo #(
    .DEPTH     ( `XBAR_MAX_TRANS ),
    .payload_t ( init_idx_t      )
  ) i_src_fifo (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .push_i  ( req_hs     ),
    .data_i  ( gnt_idx    ),
    .pop_i   ( rsp_hs     ),
    .data_o  ( head_idx   ),
    .empty_o ( fifo_empty ),
    .full_o  ( fifo_full  )
  );

  // Stalled request keeps its grant until the target accepts
  a_grant_locked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tgt_req_valid_o && !tgt_req_ready_i |=> tgt_req_valid_o && gnt_idx == $past(gnt_idx));

endmodule

/* rtl/lite_xbar.sv */
// Register-bus crossbar top level
// One decoder and demux per initiator port, one mux per target port.
// Demux outputs are indexed [initiator][target], mux inputs
// [target][initiator], and the two are crossed here

`timescale 1ns/1ps
`include "xbar_defines.svh"

module lite_xbar
  import xbar_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic       [`XBAR_N_INIT-1:0]      init_req_valid_i,
  output logic       [`XBAR_N_INIT-1:0]      init_req_ready_o,
  input  addr_t      [`XBAR_N_INIT-1:0]      init_req_addr_i,
  input  logic       [`XBAR_N_INIT-1:0]      init_req_write_i,
  input  data_t      [`XBAR_N_INIT-1:0]      init_req_wdata_i,
  output logic       [`XBAR_N_INIT-1:0]      init_rsp_valid_o,
  input  logic       [`XBAR_N_INIT-1:0]      init_rsp_ready_i,
  output data_t      [`XBAR_N_INIT-1:0]      init_rsp_rdata_o,
  output resp_e      [`XBAR_N_INIT-1:0]      init_rsp_code_o,
  output logic       [`XBAR_N_TGT-1:0]       tgt_req_valid_o,
  input  logic       [`XBAR_N_TGT-1:0]       tgt_req_ready_i,
  output addr_t      [`XBAR_N_TGT-1:0]       tgt_req_addr_o,
  output logic       [`XBAR_N_TGT-1:0]       tgt_req_write_o,
  output data_t      [`XBAR_N_TGT-1:0]       tgt_req_wdata_o,
  input  logic       [`XBAR_N_TGT-1:0]       tgt_rsp_valid_i,
  output logic       [`XBAR_N_TGT-1:0]       tgt_rsp_ready_o,
  input  data_t      [`XBAR_N_TGT-1:0]       tgt_rsp_rdata_i,
  input  resp_e      [`XBAR_N_TGT-1:0]       tgt_rsp_code_i,
  input  addr_rule_t [`XBAR_N_TGT-1:0]       addr_map_i,
  input  logic       [`XBAR_N_INIT-1:0]      en_default_i,
  input  tgt_idx_t   [`XBAR_N_INIT-1:0]      default_tgt_i
);

  // Demux side [initiator][target]
  logic  [`XBAR_N_INIT-1:0][`XBAR_N_TGT-1:0] dmx_req_valid;
  logic  [`XBAR_N_INIT-1:0][`XBAR_N_TGT-1:0] dmx_req_ready;
  addr_t [`XBAR_N_INIT-1:0][`XBAR_N_TGT-1:0] dmx_req_addr;
  logic  [`XBAR_N_INIT-1:0][`XBAR_N_TGT-1:0] dmx_req_write;
  data_t [`XBAR_N_INIT-1:0][`XBAR_N_TGT-1:0] dmx_req_wdata;
  logic  [`XBAR_N_INIT-1:0][`XBAR_N_TGT-1:0] dmx_rsp_valid;
  logic  [`XBAR_N_INIT-1:0][`XBAR_N_TGT-1:0] dmx_rsp_ready;
  data_t [`XBAR_N_INIT-1:0][`XBAR_N_TGT-1:0] dmx_rsp_rdata;
  resp_e [`XBAR_N_INIT-1:0][`XBAR_N_TGT-1:0] dmx_rsp_code;

  // Mux side [target][initiator]
  logic  [`XBAR_N_TGT-1:0][`XBAR_N_INIT-1:0] mux_req_valid;
  logic  [`XBAR_N_TGT-1:0][`XBAR_N_INIT-1:0] mux_req_ready;
  addr_t [`XBAR_N_TGT-1:0][`XBAR_N_INIT-1:0] mux_req_addr;
  logic  [`XBAR_N_TGT-1:0][`XBAR_N_INIT-1:0] mux_req_write;
  data_t [`XBAR_N_TGT-1:0][`XBAR_N_INIT-1:0] mux_req_wdata;
  logic  [`XBAR_N_TGT-1:0][`XBAR_N_INIT-1:0] mux_rsp_valid;
  logic  [`XBAR_N_TGT-1:0][`XBAR_N_INIT-1:0] mux_rsp_ready;
  data_t [`XBAR_N_TGT-1:0][`XBAR_N_INIT-1:0] mux_rsp_rdata;
  resp_e [`XBAR_N_TGT-1:0][`XBAR_N_INIT-1:0] mux_rsp_code;

  for (genvar i = 0; i < `XBAR_N_INIT; i++) begin : gen_init
    tgt_idx_t sel;  // Error index when the address is unmapped

    xbar_addr_decode i_decode (
      .addr_i        ( init_req_addr_i[i] ),
      .addr_map_i    ( addr_map_i         ),
      .en_default_i  ( en_default_i[i]    ),
      .default_tgt_i ( default_tgt_i[i]   ),
      .idx_o         ( sel                ),
      .dec_error_o   (                    )
    );

    xbar_demux i_demux (
      .clk_i            ( clk_i               ),
      .rst_n_i          ( rst_n_i             ),
      .sel_i            ( sel                 ),
      .init_req_valid_i ( init_req_valid_i[i] ),
      .init_req_ready_o ( init_req_ready_o[i] ),
      .init_req_addr_i  ( init_req_addr_i[i]  ),
      .init_req_write_i ( init_req_write_i[i] ),
      .init_req_wdata_i ( init_req_wdata_i[i] ),
      .init_rsp_valid_o ( init_rsp_valid_o[i] ),
      .init_rsp_ready_i ( init_rsp_ready_i[i] ),
      .init_rsp_rdata_o ( init_rsp_rdata_o[i] ),
      .init_rsp_code_o  ( init_rsp_code_o[i]  ),
      .tgt_req_valid_o  ( dmx_req_valid[i]    ),
      .tgt_req_ready_i  ( dmx_req_ready[i]    ),
      .tgt_req_addr_o   ( dmx_req_addr[i]     ),
      .tgt_req_write_o  ( dmx_req_write[i]    ),
      .tgt_req_wdata_o  ( dmx_req_wdata[i]    ),
      .tgt_rsp_valid_i  ( dmx_rsp_valid[i]    ),
      .tgt_rsp_ready_o  ( dmx_rsp_ready[i]    ),
      .tgt_rsp_rdata_i  ( dmx_rsp_rdata[i]    ),
      .tgt_rsp_code_i   ( dmx_rsp_code[i]     )
    );
  end

  for (genvar i = 0; i < `XBAR_N_INIT; i++) begin : gen_cross_i
    for (genvar j = 0; j < `XBAR_N_TGT; j++) begin : gen_cross_j
      assign mux_req_valid[j][i] = dmx_req_valid[i][j];
      assign mux_req_addr[j][i]  = dmx_req_addr[i][j];
      assign mux_req_write[j][i] = dmx_req_write[i][j];
      assign mux_req_wdata[j][i] = dmx_req_wdata[i][j];
      assign dmx_req_ready[i][j] = mux_req_ready[j][i];
      assign dmx_rsp_valid[i][j] = mux_rsp_valid[j][i];
      assign dmx_rsp_rdata[i][j] = mux_rsp_rdata[j][i];
      assign dmx_rsp_code[i][j]  = mux_rsp_code[j][i];
      assign mux_rsp_ready[j][i] = dmx_rsp_ready[i][j];
    end
  end

  for (genvar j = 0; j < `XBAR_N_TGT; j++) begin : gen_tgt
    xbar_mux i_mux (
      .clk_i            ( clk_i              ),
      .rst_n_i          ( rst_n_i            ),
      .init_req_valid_i ( mux_req_valid[j]   ),
      .init_req_ready_o ( mux_req_ready[j]   ),
      .init_req_addr_i  ( mux_req_addr[j]    ),
      .init_req_write_i ( mux_req_write[j]   ),
      .init_req_wdata_i ( mux_req_wdata[j]   ),
      .init_rsp_valid_o ( mux_rsp_valid[j]   ),
      .init_rsp_ready_i ( mux_rsp_ready[j]   ),
      .init_rsp_rdata_o ( mux_rsp_rdata[j]   ),
      .init_rsp_code_o  ( mux_rsp_code[j]    ),
      .tgt_req_valid_o  ( tgt_req_valid_o[j] ),
      .tgt_req_ready_i  ( tgt_req_ready_i[j] ),
      .tgt_req_addr_o   ( tgt_req_addr_o[j]  ),
      .tgt_req_write_o  ( tgt_req_write_o[j] ),
      .tgt_req_wdata_o  ( tgt_req_wdata_o[j] ),
      .tgt_rsp_valid_i  ( tgt_rsp_valid_i[j] ),
      .tgt_rsp_ready_o  ( tgt_rsp_ready_o[j] ),
      .tgt_rsp_rdata_i  ( tgt_rsp_rdata_i[j] ),
      .tgt_rsp_code_i   ( tgt_rsp_code_i[j]  )
    );
  end

endmodule

/* test/tb_target_model.sv */
// Behavioral target for the crossbar testbench
// Holds a sparse memory, raises request ready at random and returns
// responses in acceptance order after a random delay

`timescale 1ns/1ps

module tb_target_model
  import xbar_pkg::*;
#(
  parameter int unsigned SAMPLE_DLY = 45  // Sample point after the falling edge
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  req_valid_i,
  output logic  req_ready_o,
  input  addr_t req_addr_i,
  input  logic  req_write_i,
  input  data_t req_wdata_i,
  output logic  rsp_valid_o,
  input  logic  rsp_ready_i,
  output data_t rsp_rdata_o,
  output resp_e rsp_code_o
);

  data_t       mem [addr_t];  // Unwritten words read as zero
  data_t       rsp_q [$];
  int unsigned due_q [$];     // Cycle from which each response may be shown
  int unsigned cycle;
  logic        req_hs;
  logic        rsp_hs;

  initial begin
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_rdata_o = '0;
    rsp_code_o  = RESP_OKAY;
    cycle       = 0;
    req_hs      = 1'b0;
    rsp_hs      = 1'b0;
    forever begin
      @(negedge clk_i);
      cycle++;
      if (rsp_hs) begin
        rsp_valid_o = 1'b0;
      end
      if (!rsp_valid_o && due_q.size() > 0 && due_q[0] <= cycle) begin
        rsp_valid_o = 1'b1;
        rsp_rdata_o = rsp_q.pop_front();
        void'(due_q.pop_front());
      end
      req_ready_o = rst_n_i && ($urandom_range(0, 3) != 0);
      #SAMPLE_DLY;
      req_hs = req_valid_i && req_ready_o;
      rsp_hs = rsp_valid_o && rsp_ready_i;
      if (req_hs) begin
        if (req_write_i) begin
          mem[req_addr_i] = req_wdata_i;
          rsp_q.push_back('0);  // Writes answer with zero data
        end else begin
          rsp_q.push_back(mem.exists(req_addr_i) ? mem[req_addr_i] : '0);
        end
        due_q.push_back(cycle + $urandom_range(1, 6));
      end
    end
  end

endmodule

/* test/tb_lite_xbar.sv */
// Testbench for the register-bus crossbar
// Two random initiators drive the DUT, two behavioral targets answer.
// A per-initiator reference memory predicts every response, which
// must arrive in issue order

`timescale 1ns/1ps
`include "xbar_defines.svh"

module tb_lite_xbar;
  import xbar_pkg::*;

  localparam int unsigned CLK_PERIOD   = 100;
  localparam int unsigned SAMPLE_DLY   = CLK_PERIOD / 2 - 5;  // Just before the rising edge
  localparam int unsigned RESET_CYCLES = 16;
  localparam int unsigned N_RAND       = 40;
  localparam int unsigned N_FAST       = 40;
  localparam int unsigned DRAIN_CYCLES = 200;
  localparam int unsigned TOTAL_TXN    = `XBAR_N_INIT * (9 + N_RAND + N_FAST);
  localparam longint     TIMEOUT_NS    = longint'(RESET_CYCLES + 400 * TOTAL_TXN) * CLK_PERIOD;

  logic clk;
  logic rst_n;
  logic rsp_bp;  // Random response back-pressure at the initiators

  logic       [`XBAR_N_INIT-1:0] init_req_valid;
  logic       [`XBAR_N_INIT-1:0] init_req_ready;
  addr_t      [`XBAR_N_INIT-1:0] init_req_addr;
  logic       [`XBAR_N_INIT-1:0] init_req_write;
  data_t      [`XBAR_N_INIT-1:0] init_req_wdata;
  logic       [`XBAR_N_INIT-1:0] init_rsp_valid;
  logic       [`XBAR_N_INIT-1:0] init_rsp_ready;
  data_t      [`XBAR_N_INIT-1:0] init_rsp_rdata;
  resp_e      [`XBAR_N_INIT-1:0] init_rsp_code;
  logic       [`XBAR_N_TGT-1:0]  tgt_req_valid;
  logic       [`XBAR_N_TGT-1:0]  tgt_req_ready;
  addr_t      [`XBAR_N_TGT-1:0]  tgt_req_addr;
  logic       [`XBAR_N_TGT-1:0]  tgt_req_write;
  data_t      [`XBAR_N_TGT-1:0]  tgt_req_wdata;
  logic       [`XBAR_N_TGT-1:0]  tgt_rsp_valid;
  logic       [`XBAR_N_TGT-1:0]  tgt_rsp_ready;
  data_t      [`XBAR_N_TGT-1:0]  tgt_rsp_rdata;
  resp_e      [`XBAR_N_TGT-1:0]  tgt_rsp_code;
  addr_rule_t [`XBAR_N_TGT-1:0]  addr_map;
  logic       [`XBAR_N_INIT-1:0] en_default;
  tgt_idx_t   [`XBAR_N_INIT-1:0] default_tgt;

  // Reference model
  data_t ref_mem  [`XBAR_N_INIT][addr_t];
  data_t exp_data [`XBAR_N_INIT][$];
  resp_e exp_code [`XBAR_N_INIT][$];

  lite_xbar i_dut (
    .clk_i            ( clk            ),
    .rst_n_i          ( rst_n          ),
    .init_req_valid_i ( init_req_valid ),
    .init_req_ready_o ( init_req_ready ),
    .init_req_addr_i  ( init_req_addr  ),
    .init_req_write_i ( init_req_write ),
    .init_req_wdata_i ( init_req_wdata ),
    .init_rsp_valid_o ( init_rsp_valid ),
    .init_rsp_ready_i ( init_rsp_ready ),
    .init_rsp_rdata_o ( init_rsp_rdata ),
    .init_rsp_code_o  ( init_rsp_code  ),
    .tgt_req_valid_o  ( tgt_req_valid  ),
    .tgt_req_ready_i  ( tgt_req_ready  ),
    .tgt_req_addr_o   ( tgt_req_addr   ),
    .tgt_req_write_o  ( tgt_req_write  ),
    .tgt_req_wdata_o  ( tgt_req_wdata  ),
    .tgt_rsp_valid_i  ( tgt_rsp_valid  ),
    .tgt_rsp_ready_o  ( tgt_rsp_ready  ),
    .tgt_rsp_rdata_i  ( tgt_rsp_rdata  ),
    .tgt_rsp_code_i   ( tgt_rsp_code   ),
    .addr_map_i       ( addr_map       ),
    .en_default_i     ( en_default     ),
    .default_tgt_i    ( default_tgt    )
  );

  for (genvar j = 0; j < `XBAR_N_TGT; j++) begin : gen_tgt
    tb_target_model #(
      .SAMPLE_DLY ( SAMPLE_DLY )
    ) i_tgt (
      .clk_i       ( clk              ),
      .rst_n_i     ( rst_n            ),
      .req_valid_i ( tgt_req_valid[j] ),
      .req_ready_o ( tgt_req_ready[j] ),
      .req_addr_i  ( tgt_req_addr[j]  ),
      .req_write_i ( tgt_req_write[j] ),
      .req_wdata_i ( tgt_req_wdata[j] ),
      .rsp_valid_o ( tgt_rsp_valid[j] ),
      .rsp_ready_i ( tgt_rsp_ready[j] ),
      .rsp_rdata_o ( tgt_rsp_rdata[j] ),
      .rsp_code_o  ( tgt_rsp_code[j]  )
    );
  end

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_data(input int i, input data_t got, input data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t: initiator %0d response data %h, expected %h",
                          $time, i, got, exp));
    end
  endtask

  task automatic check_code(input int i, input resp_e got, input resp_e exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t: initiator %0d response code %0d, expected %0d",
                          $time, i, got, exp));
    end
  endtask

  // Predict the response of an accepted request from the fixed address map
  function automatic void model_request(input int i, input addr_t a, input logic wr,
                                        input data_t d);
    if (a >= 16'h8000 && !en_default[i]) begin
      exp_data[i].push_back('0);
      exp_code[i].push_back(RESP_DECERR);
    end else begin
      if (wr) begin
        ref_mem[i][a] = d;
        exp_data[i].push_back('0);
      end else begin
        exp_data[i].push_back(ref_mem[i].exists(a) ? ref_mem[i][a] : '0);
      end
      exp_code[i].push_back(RESP_OKAY);
    end
  endfunction

  function automatic int pending_rsp();
    int total;
    total = 0;
    for (int i = 0; i < `XBAR_N_INIT; i++) begin
      total += exp_data[i].size();
    end
    return total;
  endfunction

  // Offer one request and hold it until the DUT takes it
  task automatic issue_txn(input int i, input addr_t a, input logic wr, input data_t d);
    logic hs;
    @(negedge clk);
    init_req_valid[i] = 1'b1;
    init_req_addr[i]  = a;
    init_req_write[i] = wr;
    init_req_wdata[i] = d;
    hs = 1'b0;
    while (!hs) begin
      #SAMPLE_DLY;
      hs = init_req_ready[i];
      if (!hs) begin
        @(negedge clk);
      end
    end
    model_request(i, a, wr, d);
  endtask

  task automatic release_req(input int i);
    @(negedge clk);
    init_req_valid[i] = 1'b0;
  endtask

  task automatic collect_rsp(input int i);
    forever begin
      @(negedge clk);
      init_rsp_ready[i] = rsp_bp ? 1'($urandom_range(0, 1)) : 1'b1;
      #SAMPLE_DLY;
      if (init_rsp_valid[i] && init_rsp_ready[i]) begin
        if (exp_data[i].size() == 0) begin
          abort_run($sformatf("Initiator %0d got a response with no request outstanding", i));
        end
        check_data(i, init_rsp_rdata[i], exp_data[i].pop_front());
        check_code(i, init_rsp_code[i], exp_code[i].pop_front());
      end
    end
  endtask

  // Unmapped requests must stay inside the crossbar while defaults are off
  task automatic watch_targets();
    forever begin
      @(negedge clk);
      #SAMPLE_DLY;
      for (int j = 0; j < `XBAR_N_TGT; j++) begin
        if (tgt_req_valid[j] && tgt_req_addr[j] >= 16'h8000 && en_default == '0) begin
          abort_run($sformatf("Unmapped address %h reached target port %0d",
                              tgt_req_addr[j], j));
        end
      end
    end
  endtask

  task automatic run_directed(input int i);
    addr_t base;
    base = addr_t'(i) << 4;  // Bit 4 keeps the initiators apart
    issue_txn(i, 16'h0100 | base, 1'b1, $urandom());
    issue_txn(i, 16'h0100 | base, 1'b0, '0);
    issue_txn(i, 16'h4200 | base, 1'b1, $urandom());
    issue_txn(i, 16'h4200 | base, 1'b0, '0);
    issue_txn(i, 16'h0300 | base, 1'b0, '0);  // Never written
    issue_txn(i, 16'h9000 | base, 1'b1, $urandom());
    issue_txn(i, 16'h9000 | base, 1'b0, '0);
    release_req(i);
  endtask

  task automatic run_default(input int i);
    addr_t base;
    base = addr_t'(i) << 4;
    issue_txn(i, 16'hA000 | base, 1'b1, $urandom());
    issue_txn(i, 16'hA000 | base, 1'b0, '0);
    release_req(i);
  endtask

  task automatic run_random(input int i, input int unsigned n, input logic fast);
    addr_t a;
    for (int unsigned k = 0; k < n; k++) begin
      if (!fast && $urandom_range(0, 2) == 0) begin
        release_req(i);
        repeat ($urandom_range(1, 4)) @(negedge clk);
      end
      // Region 0 and 1 map to the targets, region 2 is unmapped
      a = addr_t'(($urandom_range(0, 2) << 14) | ($urandom_range(0, 7) << 5) | (i << 4));
      issue_txn(i, a, 1'($urandom_range(0, 1)), $urandom());
    end
    release_req(i);
  endtask

  task automatic drain_rsp();
    for (int unsigned c = 0; c < DRAIN_CYCLES && pending_rsp() > 0; c++) begin
      @(negedge clk);
    end
  endtask

  initial begin
    void'($urandom(32'h76da));
    clk            = 1'b0;
    rst_n          = 1'b0;
    rsp_bp         = 1'b0;
    init_req_valid = '0;
    init_req_addr  = '0;
    init_req_write = '0;
    init_req_wdata = '0;
    init_rsp_ready = '0;
    en_default     = '0;
    default_tgt    = '0;
    addr_map[0]    = '{idx: tgt_idx_t'(0), start_addr: 16'h0000, end_addr: 16'h4000};
    addr_map[1]    = '{idx: tgt_idx_t'(1), start_addr: 16'h4000, end_addr: 16'h8000};
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    fork
      collect_rsp(0);
      collect_rsp(1);
      watch_targets();
    join_none

    fork
      run_directed(0);
      run_directed(1);
    join
    drain_rsp();

    @(negedge clk);
    en_default  = '1;
    default_tgt = {`XBAR_N_INIT{tgt_idx_t'(1)}};
    fork
      run_default(0);
      run_default(1);
    join
    drain_rsp();

    @(negedge clk);
    en_default = '0;
    fork
      run_random(0, N_RAND, 1'b0);
      run_random(1, N_RAND, 1'b0);
    join
    drain_rsp();

    rsp_bp = 1'b1;
    fork
      run_random(0, N_FAST, 1'b1);
      run_random(1, N_FAST, 1'b1);
    join
    drain_rsp();
    repeat (10) @(negedge clk);  // Catch late duplicates

    if (pending_rsp() != 0) begin
      abort_run($sformatf("%0d responses never arrived", pending_rsp()));
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

  initial begin
    #(TIMEOUT_NS);
    abort_run("Watchdog timeout, the transactions did not complete in time");
  end

endmodule

/* files.f */
+incdir+common
common/xbar_pkg.sv
rtl/xbar_fifo.sv
rtl/xbar_addr_decode.sv
demux/xbar_demux.sv
mux/xbar_mux.sv
rtl/lite_xbar.sv
test/tb_target_model.sv
test/tb_lite_xbar.sv

/* Makefile */
SRCS := $(filter %.sv,$(shell cat files.f))

.PHONY: all run clean

all: run

obj_dir/Vtb_lite_xbar: files.f $(SRCS) common/xbar_defines.svh
	verilator --binary --timing --assert -f files.f --top-module tb_lite_xbar -o Vtb_lite_xbar

run: obj_dir/Vtb_lite_xbar
	@out="$$(./obj_dir/Vtb_lite_xbar)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
